/* synth_lab_top.f */
+incdir+src
src/synth_lab_pkg.sv
src/key_hold_tracker.sv
src/cursor_mover.sv
src/lfsr_tick.sv
src/pixel_stage.sv
src/pixel_compositor.sv
src/synth_lab_top.sv
bench/tb_synth_lab_top.sv

/* Makefile */
# Verilator build and run of the synth_lab_top testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build folder and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing -j 0 --top-module tb_synth_lab_top -Mdir obj_dir -f synth_lab_top.f
	./obj_dir/Vtb_synth_lab_top > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then echo "simulation ended early, see $(LOG)"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)

/* bench/tb_synth_lab_top.sv */
`timescale 1ns/1ps
`include "scan_codes.svh"

module tb_synth_lab_top;

localparam int STEP_DIV     = 4;
localparam int SLOW_FACTOR  = 4;
localparam int LFSR_DIV     = 8;
localparam int RESET_CYCLES = 8;
localparam logic [31:0] SEED = 32'd54902;
localparam int HOME_X = synth_lab_pkg::CURSOR_HOME_X;
localparam int HOME_Y = synth_lab_pkg::CURSOR_HOME_Y;

// rough length of each test in cycles, limit is twice the sum
localparam int LFSR_CYCLES  = 32 * LFSR_DIV;
localparam int KEY_CYCLES   = 4 * 14 * 2;
localparam int MOVE_CYCLES  = 6 * STEP_DIV * (4 + SLOW_FACTOR);
localparam int CLAMP_CYCLES = 2 * (HOME_X + 8) * STEP_DIV;
localparam int PIXEL_CYCLES = 20 * (30 + 40) + (synth_lab_pkg::NOISE_Y0 - HOME_Y) * STEP_DIV;
localparam int MAX_CYCLES   = 2 * (LFSR_CYCLES + KEY_CYCLES + MOVE_CYCLES + CLAMP_CYCLES
                                   + PIXEL_CYCLES + 10 * RESET_CYCLES);

logic                         CLK_25MHZ;
logic                         reset_from_key;
logic [7:0]                   key_event;
logic                         event_valid;
synth_lab_pkg::pixel_req_t    pix_in;
logic                         pix_in_valid;
logic                         pix_in_ready;
synth_lab_pkg::rgb24_t        pix_out;
logic                         pix_out_valid;
logic                         pix_out_ready;
synth_lab_pkg::held_keys_t    held_keys;
synth_lab_pkg::cursor_state_t cursor_pos;
logic [4:0]                   lfsr_value;

logic [31:0] rng_state;
int          check_count;
int          error_count;
int          cycle_count = 0;

synth_lab_top #(
   .STEP_DIV   (STEP_DIV),
   .SLOW_FACTOR(SLOW_FACTOR),
   .LFSR_DIV   (LFSR_DIV)
) u_synth_lab_top (
   .CLK_25MHZ     (CLK_25MHZ),
   .reset_from_key(reset_from_key),
   .key_event     (key_event),
   .event_valid   (event_valid),
   .pix_in        (pix_in),
   .pix_in_valid  (pix_in_valid),
   .pix_in_ready  (pix_in_ready),
   .pix_out       (pix_out),
   .pix_out_valid (pix_out_valid),
   .pix_out_ready (pix_out_ready),
   .held_keys     (held_keys),
   .cursor_pos    (cursor_pos),
   .lfsr_value    (lfsr_value)
);

always #20 CLK_25MHZ = ~CLK_25MHZ;   // 40 ns period

always @(posedge CLK_25MHZ)
begin
   cycle_count <= cycle_count + 1;
   if (cycle_count >= MAX_CYCLES)
   begin
      $display("Timeout: run stopped after %0d cycles", cycle_count);
      $display("TESTBENCH FAILED");
      $finish;
   end
end

////////////////////////////////////////
// helpers
////////////////////////////////////////
function automatic int unsigned next_rand();
   rng_state = rng_state * 32'd1103515245 + 32'd12345;
   return rng_state >> 8;   // low bits of an lcg are weak
endfunction

function automatic synth_lab_pkg::cursor_state_t make_cursor(input int x, input int y,
                                                             input int idx);
   synth_lab_pkg::cursor_state_t c;
   c.x           = synth_lab_pkg::coord_t'(x);
   c.y           = synth_lab_pkg::coord_t'(y);
   c.palette_idx = synth_lab_pkg::palette_idx_t'(idx);
   return c;
endfunction

// reference colour rule, cursor over bar over background
function automatic synth_lab_pkg::rgb24_t expected_colour(input synth_lab_pkg::pixel_req_t req,
                                                          input synth_lab_pkg::cursor_state_t cur,
                                                          input logic [4:0] noise);
   synth_lab_pkg::rgb24_t c;
   logic [11:0]           tone;
   int                    px;
   int                    py;
   px = int'(req.x);
   py = int'(req.y);
   if (px >= int'(cur.x) && px < int'(cur.x) + synth_lab_pkg::CURSOR_SIZE
       && py >= int'(cur.y) && py < int'(cur.y) + synth_lab_pkg::CURSOR_SIZE)
   begin
      case (cur.palette_idx)
         2'd0:    tone = 12'hfff;   // white
         2'd1:    tone = 12'hf00;
         2'd2:    tone = 12'h0f0;
         default: tone = 12'h00f;
      endcase
      c.r = {tone[11:8], 4'h0};
      c.g = {tone[7:4], 4'h0};
      c.b = {tone[3:0], 4'h0};
   end
   else if (py >= synth_lab_pkg::NOISE_Y0 && py < synth_lab_pkg::NOISE_Y0 + synth_lab_pkg::NOISE_H)
   begin
      c.r = 8'hff;
      c.g = {noise, 3'b000};
      c.b = 8'h00;
   end
   else
      c = req.bg;
   return c;
endfunction

// one third each: on the cursor, on the bar, anywhere
function automatic synth_lab_pkg::pixel_req_t random_request();
   synth_lab_pkg::pixel_req_t req;
   logic [23:0]               bits;
   int unsigned               kind;
   kind = next_rand() % 3;
   if (kind == 0)
   begin
      req.x = synth_lab_pkg::coord_t'(int'(cursor_pos.x) + int'(next_rand() % 8));
      req.y = synth_lab_pkg::coord_t'(int'(cursor_pos.y) + int'(next_rand() % 8));
   end
   else if (kind == 1)
   begin
      req.x = synth_lab_pkg::coord_t'(next_rand() % synth_lab_pkg::SCREEN_W);
      req.y = synth_lab_pkg::coord_t'(synth_lab_pkg::NOISE_Y0 + int'(next_rand() % 16));
   end
   else
   begin
      req.x = synth_lab_pkg::coord_t'(next_rand() % synth_lab_pkg::SCREEN_W);
      req.y = synth_lab_pkg::coord_t'(next_rand() % synth_lab_pkg::SCREEN_H);
   end
   bits   = 24'(next_rand());
   req.bg = bits;
   return req;
endfunction

task automatic note_failure(input string msg);
   error_count++;
   $display("Error: %s", msg);
endtask

task automatic next_cycle();
   @(posedge CLK_25MHZ);
   #2;
endtask

task automatic apply_reset();
   reset_from_key = 1'b1;
   event_valid    = 1'b0;
   pix_in_valid   = 1'b0;
   pix_out_ready  = 1'b1;
   repeat (RESET_CYCLES) @(posedge CLK_25MHZ);
   #2;
   reset_from_key = 1'b0;
endtask

task automatic send_key(input logic [7:0] code);
   key_event   = code;
   event_valid = 1'b1;
   next_cycle();
   event_valid = 1'b0;
endtask

////////////////////////////////////////
// compare tasks
////////////////////////////////////////
task automatic check_keys(input string name, input synth_lab_pkg::held_keys_t exp,
                          input synth_lab_pkg::held_keys_t act);
   check_count++;
   if (act !== exp)
   begin
      error_count++;
      $display("Fail %s: expected %h actual %h", name, exp, act);
   end
endtask

task automatic check_cursor(input string name, input synth_lab_pkg::cursor_state_t exp,
                            input synth_lab_pkg::cursor_state_t act);
   check_count++;
   if (act !== exp)
   begin
      error_count++;
      $display("Fail %s: expected x=%0d y=%0d idx=%0d actual x=%0d y=%0d idx=%0d", name,
               exp.x, exp.y, exp.palette_idx, act.x, act.y, act.palette_idx);
   end
endtask

task automatic check_rgb(input string name, input synth_lab_pkg::rgb24_t exp,
                         input synth_lab_pkg::rgb24_t act);
   check_count++;
   if (act !== exp)
   begin
      error_count++;
      $display("Fail %s: expected %h actual %h", name, exp, act);
   end
endtask

task automatic check_lfsr(input string name, input logic [4:0] exp, input logic [4:0] act);
   check_count++;
   if (act !== exp)
   begin
      error_count++;
      $display("Fail %s: expected %h actual %h", name, exp, act);
   end
endtask

////////////////////////////////////////
// reset state and lfsr
////////////////////////////////////////
task automatic lfsr_sequence_test();
   logic [4:0] model;
   int         waited;
   apply_reset();
   check_keys("reset keys", '0, held_keys);
   check_cursor("reset cursor", make_cursor(HOME_X, HOME_Y, 0), cursor_pos);
   check_lfsr("reset lfsr", 5'd1, lfsr_value);
   if (pix_in_ready !== 1'b1 || pix_out_valid !== 1'b0)
      note_failure("pixel handshake not idle after reset");
   model = 5'd1;
   for (int n = 0; n < 31; n++)
   begin
      waited = 0;
      while (lfsr_value == model && waited < LFSR_DIV)
      begin
         next_cycle();
         waited++;
      end
      if (lfsr_value == model)
      begin
         note_failure($sformatf("lfsr held %h longer than %0d cycles", model, LFSR_DIV));
         break;
      end
      model = {model[3:0], model[4] ^ model[2]};   // x^5 + x^3 + 1
      check_lfsr($sformatf("lfsr step %0d", n + 1), model, lfsr_value);
   end
endtask

////////////////////////////////////////
// key map
////////////////////////////////////////
task automatic key_map_test();
   logic [7:0]  make_codes [14];
   logic [7:0]  break_codes [14];
   logic [7:0]  unknown_codes [4];
   logic [14:0] model;
   // same order as the bitmap, digit_1 at the top
   make_codes    = '{`SC_MAKE_1, `SC_MAKE_2, `SC_MAKE_3, `SC_MAKE_4, `SC_MAKE_5,
                     `SC_MAKE_6, `SC_MAKE_7, `SC_MAKE_8, `SC_MAKE_M, `SC_MAKE_SPACE,
                     `SC_MAKE_LEFT, `SC_MAKE_RIGHT, `SC_MAKE_UP, `SC_MAKE_DOWN};
   break_codes   = '{`SC_BREAK_1, `SC_BREAK_2, `SC_BREAK_3, `SC_BREAK_4, `SC_BREAK_5,
                     `SC_BREAK_6, `SC_BREAK_7, `SC_BREAK_8, `SC_BREAK_M, `SC_BREAK_SPACE,
                     `SC_BREAK_LEFT, `SC_BREAK_RIGHT, `SC_BREAK_UP, `SC_BREAK_DOWN};
   unknown_codes = '{8'h00, 8'h5a, 8'hf0, 8'h11};
   apply_reset();
   model = '0;
   for (int i = 0; i < 14; i++)
   begin
      send_key(make_codes[i]);
      model[14 - i] = 1'b1;
      check_keys($sformatf("make key %0d", i), model, held_keys);
      send_key(unknown_codes[i % 4]);
      check_keys("unknown code", model, held_keys);
   end
   for (int i = 0; i < 14; i++)
   begin
      send_key(break_codes[i]);
      model[14 - i] = 1'b0;
      check_keys($sformatf("break key %0d", i), model, held_keys);
   end
endtask

////////////////////////////////////////
// cursor motion
////////////////////////////////////////
task automatic wait_cursor_move(input string name, input int limit, output int cycles);
   synth_lab_pkg::cursor_state_t start;
   start  = cursor_pos;
   cycles = 0;
   while (cursor_pos == start && cycles < limit)
   begin
      next_cycle();
      cycles++;
   end
   if (cursor_pos == start)
      note_failure($sformatf("%s: cursor did not move within %0d cycles", name, limit));
endtask

// first move lands anywhere in the interval, later ones exactly on it
task automatic measure_steps(input string name, input logic [7:0] make_code,
                             input logic [7:0] break_code, input int dx, input int dy,
                             input int interval);
   synth_lab_pkg::cursor_state_t prev;
   int                           cycles;
   send_key(make_code);
   for (int n = 0; n < 4; n++)
   begin
      prev = cursor_pos;
      wait_cursor_move(name, interval, cycles);
      if (n > 0 && cycles != interval)
         note_failure($sformatf("%s: step took %0d cycles, not %0d", name, cycles, interval));
      check_cursor(name, make_cursor(int'(prev.x) + dx, int'(prev.y) + dy,
                                     int'(prev.palette_idx)), cursor_pos);
   end
   send_key(break_code);
   repeat (interval) next_cycle();
endtask

task automatic run_to_edge(input string name, input logic [7:0] make_code,
                           input logic [7:0] break_code, input int limit_x);
   synth_lab_pkg::cursor_state_t prev;
   synth_lab_pkg::cursor_state_t exp;
   int                           cycles;
   int                           dx;
   dx = (limit_x == 0) ? -1 : 1;
   send_key(make_code);
   while (int'(cursor_pos.x) != limit_x)
   begin
      prev = cursor_pos;
      exp  = make_cursor(int'(prev.x) + dx, int'(prev.y), int'(prev.palette_idx));
      wait_cursor_move(name, STEP_DIV, cycles);
      check_cursor(name, exp, cursor_pos);
      if (cursor_pos !== exp)
         break;
   end
   // stay pressed at the edge, x must not move
   repeat (4 * STEP_DIV) next_cycle();
   check_cursor({name, " clamp"}, make_cursor(limit_x, HOME_Y, 0), cursor_pos);
   send_key(break_code);
endtask

task automatic cursor_motion_test();
   apply_reset();
   measure_steps("move right", `SC_MAKE_RIGHT, `SC_BREAK_RIGHT, 1, 0, STEP_DIV);
   measure_steps("move down", `SC_MAKE_DOWN, `SC_BREAK_DOWN, 0, 1, STEP_DIV);
   measure_steps("move left", `SC_MAKE_LEFT, `SC_BREAK_LEFT, -1, 0, STEP_DIV);
   measure_steps("move up", `SC_MAKE_UP, `SC_BREAK_UP, 0, -1, STEP_DIV);
   send_key(`SC_MAKE_M);   // slow mode
   measure_steps("slow right", `SC_MAKE_RIGHT, `SC_BREAK_RIGHT, 1, 0, STEP_DIV * SLOW_FACTOR);
   send_key(`SC_BREAK_M);
   apply_reset();
   run_to_edge("clamp left", `SC_MAKE_LEFT, `SC_BREAK_LEFT, 0);
   apply_reset();
   run_to_edge("clamp right", `SC_MAKE_RIGHT, `SC_BREAK_RIGHT,
               synth_lab_pkg::SCREEN_W - synth_lab_pkg::CURSOR_SIZE);
endtask

task automatic palette_test();
   apply_reset();
   for (int n = 1; n <= 5; n++)
   begin
      send_key(`SC_MAKE_SPACE);
      next_cycle();   // index follows the held bit by a cycle
      check_cursor($sformatf("palette press %0d", n), make_cursor(HOME_X, HOME_Y, n % 4),
                   cursor_pos);
      send_key(`SC_BREAK_SPACE);
   end
endtask

////////////////////////////////////////
// pixel path
////////////////////////////////////////
// handshakes sampled mid-cycle, inputs change 2 ns after the edge
task automatic run_burst(input string name, input int count, input bit stall);
   synth_lab_pkg::rgb24_t expected_q [$];
   synth_lab_pkg::rgb24_t held_value;
   bit                    was_stalled;
   bit                    in_fire;
   bit                    out_fire;
   int                    sent;
   int                    received;
   int                    cycles;
   sent          = 0;
   received      = 0;
   cycles        = 0;
   was_stalled   = 1'b0;
   pix_in        = random_request();
   pix_in_valid  = 1'b1;
   pix_out_ready = stall ? ((next_rand() % 3) != 0) : 1'b1;
   while (received < count && cycles < 20 * count)
   begin
      @(negedge CLK_25MHZ);
      in_fire  = pix_in_valid && pix_in_ready;
      out_fire = pix_out_valid && pix_out_ready;
      if (was_stalled)
      begin
         if (!pix_out_valid)
            note_failure($sformatf("%s: pix_out_valid dropped while stalled", name));
         check_rgb({name, " hold"}, held_value, pix_out);
      end
      if (out_fire)
      begin
         if (expected_q.size() == 0)
            note_failure($sformatf("%s: result with no request behind it", name));
         else
            check_rgb(name, expected_q.pop_front(), pix_out);
         received++;
      end
      if (in_fire)
         expected_q.push_back(expected_colour(pix_in, cursor_pos, lfsr_value));
      was_stalled = pix_out_valid && !pix_out_ready;
      held_value  = pix_out;
      next_cycle();
      cycles++;
      if (in_fire)
      begin
         sent++;
         if (sent < count)
            pix_in = random_request();
         else
            pix_in_valid = 1'b0;
      end
      if (stall)
         pix_out_ready = (next_rand() % 3) != 0;
   end
   if (received < count)
      note_failure($sformatf("%s: only %0d of %0d results arrived", name, received, count));
   pix_out_ready = 1'b1;
   repeat (4) next_cycle();
   if (pix_out_valid)
      note_failure($sformatf("%s: extra result after the burst", name));
endtask

task automatic colour_test();
   apply_reset();
   send_key(`SC_MAKE_SPACE);   // red cursor
   send_key(`SC_BREAK_SPACE);
   // park the cursor across the top rows of the noise bar
   send_key(`SC_MAKE_DOWN);
   while (int'(cursor_pos.y) != synth_lab_pkg::NOISE_Y0 - 4)
      next_cycle();
   send_key(`SC_BREAK_DOWN);
   run_burst("colour", 30, 1'b0);
endtask

task automatic back_pressure_test();
   apply_reset();
   run_burst("back pressure", 40, 1'b1);
endtask

initial
begin
   CLK_25MHZ      = 1'b0;
   reset_from_key = 1'b1;
   key_event      = 8'h00;
   event_valid    = 1'b0;
   pix_in         = '0;
   pix_in_valid   = 1'b0;
   pix_out_ready  = 1'b1;
   rng_state      = SEED;
   check_count    = 0;
   error_count    = 0;

   lfsr_sequence_test();
   key_map_test();
   cursor_motion_test();
   palette_test();
   colour_test();
   back_pressure_test();

   $display("checks %0d, errors %0d", check_count, error_count);
   if (error_count == 0)
      $display("TESTBENCH PASSED");
   else
      $display("TESTBENCH FAILED");
   $finish;
end

endmodule

/* src/synth_lab_top.sv */
`timescale 1ns/1ps

module synth_lab_top #(
   parameter int STEP_DIV    = 250000,
   parameter int SLOW_FACTOR = 4,
   parameter int LFSR_DIV    = 25000000
) (
   input  logic                         CLK_25MHZ,
   input  logic                         reset_from_key,
   input  logic [7:0]                   key_event,
   input  logic                         event_valid,
   input  synth_lab_pkg::pixel_req_t    pix_in,
   input  logic                         pix_in_valid,
   output logic                         pix_in_ready,
   output synth_lab_pkg::rgb24_t        pix_out,
   output logic                         pix_out_valid,
   input  logic                         pix_out_ready,
   output synth_lab_pkg::held_keys_t    held_keys,
   output synth_lab_pkg::cursor_state_t cursor_pos,
   output logic [4:0]                   lfsr_value
);

////////////////////////////////////////
// keyboard side
////////////////////////////////////////
key_hold_tracker u_key_hold_tracker (
   .CLK_25MHZ     (CLK_25MHZ),
   .reset_from_key(reset_from_key),
   .key_event     (key_event),
   .event_valid   (event_valid),
   .held          (held_keys)
);

cursor_mover #(
   .STEP_DIV   (STEP_DIV),
   .SLOW_FACTOR(SLOW_FACTOR)
) u_cursor_mover (
   .CLK_25MHZ     (CLK_25MHZ),
   .reset_from_key(reset_from_key),
   .held          (held_keys),
   .cursor        (cursor_pos)
);

lfsr_tick #(
   .LFSR_DIV(LFSR_DIV)
) u_lfsr_tick (
   .CLK_25MHZ     (CLK_25MHZ),
   .reset_from_key(reset_from_key),
   .lfsr_value    (lfsr_value)
);

////////////////////////////////////////
// pixel path
////////////////////////////////////////
pixel_compositor u_pixel_compositor (
   .CLK_25MHZ     (CLK_25MHZ),
   .reset_from_key(reset_from_key),
   .cursor        (cursor_pos),
   .lfsr_value    (lfsr_value),
   .pix_in        (pix_in),
   .pix_in_valid  (pix_in_valid),
   .pix_in_ready  (pix_in_ready),
   .pix_out       (pix_out),
   .pix_out_valid (pix_out_valid),
   .pix_out_ready (pix_out_ready)
);

endmodule

/* src/pixel_compositor.sv */
`timescale 1ns/1ps

module pixel_compositor (
   input  logic                         CLK_25MHZ,
   input  logic                         reset_from_key,
   input  synth_lab_pkg::cursor_state_t cursor,
   input  logic [4:0]                   lfsr_value,
   input  synth_lab_pkg::pixel_req_t    pix_in,
   input  logic                         pix_in_valid,
   output logic                         pix_in_ready,
   output synth_lab_pkg::rgb24_t        pix_out,
   output logic                         pix_out_valid,
   input  logic                         pix_out_ready
);

localparam synth_lab_pkg::coord_t CURSOR_LAST =
   synth_lab_pkg::coord_t'(synth_lab_pkg::CURSOR_SIZE - 1);
localparam synth_lab_pkg::coord_t BAR_TOP =
   synth_lab_pkg::coord_t'(synth_lab_pkg::NOISE_Y0);
localparam synth_lab_pkg::coord_t BAR_BOTTOM =
   synth_lab_pkg::coord_t'(synth_lab_pkg::NOISE_Y0 + synth_lab_pkg::NOISE_H - 1);

synth_lab_pkg::pixel_mid_t mid_in;
synth_lab_pkg::pixel_mid_t mid_out;
logic                      mid_valid;
logic                      mid_ready;
synth_lab_pkg::rgb24_t     colour;

////////////////////////////////////////
// stage 1, hit tests
////////////////////////////////////////
// cursor and lfsr get sampled with the request
always_comb
begin
   mid_in.bg         = pix_in.bg;
   mid_in.cursor_hit = (pix_in.x >= cursor.x) && (pix_in.x <= cursor.x + CURSOR_LAST)
                    && (pix_in.y >= cursor.y) && (pix_in.y <= cursor.y + CURSOR_LAST);
   mid_in.bar_hit    = (pix_in.y >= BAR_TOP) && (pix_in.y <= BAR_BOTTOM);
   mid_in.cursor_rgb = synth_lab_pkg::CURSOR_PALETTE[cursor.palette_idx];
   mid_in.noise      = lfsr_value;
end

pixel_stage #(
   .payload_t(synth_lab_pkg::pixel_mid_t)
) u_hit_stage (
   .CLK_25MHZ     (CLK_25MHZ),
   .reset_from_key(reset_from_key),
   .in_data       (mid_in),
   .in_valid      (pix_in_valid),
   .in_ready      (pix_in_ready),
   .out_data      (mid_out),
   .out_valid     (mid_valid),
   .out_ready     (mid_ready)
);

////////////////////////////////////////
// stage 2, priority colour select
////////////////////////////////////////
always_comb
begin
   if (mid_out.cursor_hit)
      colour = '{r: {mid_out.cursor_rgb.r, 4'h0},
                 g: {mid_out.cursor_rgb.g, 4'h0},
                 b: {mid_out.cursor_rgb.b, 4'h0}};
   else if (mid_out.bar_hit)
      colour = '{r: 8'hff, g: {mid_out.noise, 3'b000}, b: 8'h00};   // noise in green
   else
      colour = mid_out.bg;
end

pixel_stage #(
   .payload_t(synth_lab_pkg::rgb24_t)
) u_colour_stage (
   .CLK_25MHZ     (CLK_25MHZ),
   .reset_from_key(reset_from_key),
   .in_data       (colour),
   .in_valid      (mid_valid),
   .in_ready      (mid_ready),
   .out_data      (pix_out),
   .out_valid     (pix_out_valid),
   .out_ready     (pix_out_ready)
);

endmodule

/* src/pixel_stage.sv */
`timescale 1ns/1ps

module pixel_stage #(
   parameter type payload_t = logic [7:0]
) (
   input  logic     CLK_25MHZ,
   input  logic     reset_from_key,
   input  payload_t in_data,
   input  logic     in_valid,
   output logic     in_ready,
   output payload_t out_data,
   output logic     out_valid,
   input  logic     out_ready
);

// open when empty or when the held item leaves this cycle
assign in_ready = !out_valid || out_ready;

always_ff @(posedge CLK_25MHZ)
begin
   if (reset_from_key)
      out_valid <= 1'b0;
   else if (in_ready)
      out_valid <= in_valid;
end

// payload only moves on a transfer, holds while stalled
always_ff @(posedge CLK_25MHZ)
begin
   if (in_ready && in_valid)
      out_data <= in_data;
end

endmodule

/* src/lfsr_tick.sv */
`timescale 1ns/1ps

module lfsr_tick #(
   parameter int LFSR_DIV = 25000000
) (
   input  logic       CLK_25MHZ,
   input  logic       reset_from_key,
   output logic [4:0] lfsr_value
);

localparam int CNT_W = $clog2(LFSR_DIV + 1);

logic [CNT_W-1:0] div_count;
logic             tick;

// terminal count, one tick per LFSR_DIV cycles
assign tick = (div_count == CNT_W'(LFSR_DIV - 1));

always_ff @(posedge CLK_25MHZ)
begin
   if (reset_from_key)
      div_count <= '0;
   else if (tick)
      div_count <= '0;
   else
      div_count <= div_count + 1'b1;
end

////////////////////////////////////////
// 5-bit fibonacci lfsr, x^5 + x^3 + 1
////////////////////////////////////////
always_ff @(posedge CLK_25MHZ)
begin
   if (reset_from_key)
      lfsr_value <= 5'd1;   // seed, any nonzero works
   else if (tick)
      lfsr_value <= {lfsr_value[3:0], lfsr_value[4] ^ lfsr_value[2]};
end

endmodule

/* src/cursor_mover.sv */
`timescale 1ns/1ps

module cursor_mover #(
   parameter int STEP_DIV    = 250000,
   parameter int SLOW_FACTOR = 4
) (
   input  logic                         CLK_25MHZ,
   input  logic                         reset_from_key,
   input  synth_lab_pkg::held_keys_t    held,
   output synth_lab_pkg::cursor_state_t cursor
);

localparam int SLOW_DIV = STEP_DIV * SLOW_FACTOR;
localparam int DIV_W    = $clog2(SLOW_DIV + 1);

// largest top-left corner that keeps the square on screen
localparam synth_lab_pkg::coord_t X_MAX =
   synth_lab_pkg::coord_t'(synth_lab_pkg::SCREEN_W - synth_lab_pkg::CURSOR_SIZE);
localparam synth_lab_pkg::coord_t Y_MAX =
   synth_lab_pkg::coord_t'(synth_lab_pkg::SCREEN_H - synth_lab_pkg::CURSOR_SIZE);

logic [DIV_W-1:0]            div_count;
logic [DIV_W-1:0]            div_limit;
logic                        m_q;
logic                        m_change;
logic                        step;
logic                        space_q;
synth_lab_pkg::coord_t       pos_x;
synth_lab_pkg::coord_t       pos_y;
synth_lab_pkg::palette_idx_t palette_idx;

////////////////////////////////////////
// step divider
////////////////////////////////////////
assign div_limit = held.m ? DIV_W'(SLOW_DIV - 1) : DIV_W'(STEP_DIV - 1);
assign m_change  = held.m ^ m_q;
assign step      = !m_change && (div_count == div_limit);   // no step on mode switch

always_ff @(posedge CLK_25MHZ)
begin
   if (reset_from_key)
   begin
      div_count <= '0;
      m_q       <= 1'b0;
   end
   else
   begin
      m_q <= held.m;
      if (m_change || step)
         div_count <= '0;   // count restarts when m toggles
      else
         div_count <= div_count + 1'b1;
   end
end

////////////////////////////////////////
// position, clamped at the edges
////////////////////////////////////////
always_ff @(posedge CLK_25MHZ)
begin
   if (reset_from_key)
   begin
      pos_x <= synth_lab_pkg::coord_t'(synth_lab_pkg::CURSOR_HOME_X);
      pos_y <= synth_lab_pkg::coord_t'(synth_lab_pkg::CURSOR_HOME_Y);
   end
   else if (step)
   begin
      // opposite keys cancel
      if (held.left && !held.right && pos_x != '0)
         pos_x <= pos_x - 1'b1;
      else if (held.right && !held.left && pos_x < X_MAX)
         pos_x <= pos_x + 1'b1;

      if (held.up && !held.down && pos_y != '0)
         pos_y <= pos_y - 1'b1;   // screen y grows downward
      else if (held.down && !held.up && pos_y < Y_MAX)
         pos_y <= pos_y + 1'b1;
   end
end

// palette index steps on each space press, wraps 3 -> 0
always_ff @(posedge CLK_25MHZ)
begin
   if (reset_from_key)
   begin
      space_q     <= 1'b0;
      palette_idx <= '0;
   end
   else
   begin
      space_q <= held.space;
      if (held.space && !space_q)
         palette_idx <= palette_idx + 1'b1;
   end
end

assign cursor = '{x: pos_x, y: pos_y, palette_idx: palette_idx};

endmodule

/* src/key_hold_tracker.sv */
`timescale 1ns/1ps
`include "scan_codes.svh"

module key_hold_tracker (
   input  logic                      CLK_25MHZ,
   input  logic                      reset_from_key,
   input  logic [7:0]                key_event,
   input  logic                      event_valid,
   output synth_lab_pkg::held_keys_t held
);

////////////////////////////////////////
// held-key bitmap
////////////////////////////////////////
// one bit changes per event, spare bit only ever sees reset
always_ff @(posedge CLK_25MHZ)
begin
   if (reset_from_key)
   begin
      held <= '0;
   end
   else if (event_valid)
   begin
      case (key_event)
         `SC_MAKE_1:      held.digit_1 <= 1'b1;
         `SC_BREAK_1:     held.digit_1 <= 1'b0;
         `SC_MAKE_2:      held.digit_2 <= 1'b1;
         `SC_BREAK_2:     held.digit_2 <= 1'b0;
         `SC_MAKE_3:      held.digit_3 <= 1'b1;
         `SC_BREAK_3:     held.digit_3 <= 1'b0;
         `SC_MAKE_4:      held.digit_4 <= 1'b1;
         `SC_BREAK_4:     held.digit_4 <= 1'b0;
         `SC_MAKE_5:      held.digit_5 <= 1'b1;
         `SC_BREAK_5:     held.digit_5 <= 1'b0;
         `SC_MAKE_6:      held.digit_6 <= 1'b1;
         `SC_BREAK_6:     held.digit_6 <= 1'b0;
         `SC_MAKE_7:      held.digit_7 <= 1'b1;
         `SC_BREAK_7:     held.digit_7 <= 1'b0;
         `SC_MAKE_8:      held.digit_8 <= 1'b1;
         `SC_BREAK_8:     held.digit_8 <= 1'b0;

         // motion modifiers
         `SC_MAKE_M:      held.m       <= 1'b1;
         `SC_BREAK_M:     held.m       <= 1'b0;
         `SC_MAKE_SPACE:  held.space   <= 1'b1;
         `SC_BREAK_SPACE: held.space   <= 1'b0;

         // arrows
         `SC_MAKE_LEFT:   held.left    <= 1'b1;
         `SC_BREAK_LEFT:  held.left    <= 1'b0;
         `SC_MAKE_RIGHT:  held.right   <= 1'b1;
         `SC_BREAK_RIGHT: held.right   <= 1'b0;
         `SC_MAKE_UP:     held.up      <= 1'b1;
         `SC_BREAK_UP:    held.up      <= 1'b0;
         `SC_MAKE_DOWN:   held.down    <= 1'b1;
         `SC_BREAK_DOWN:  held.down    <= 1'b0;

         default:
         begin
            // unknown code, map untouched
         end
      endcase
   end
end

endmodule

/* src/synth_lab_pkg.sv */
package synth_lab_pkg;

   ////////////////////////////////////////
   // screen geometry
   ////////////////////////////////////////
   localparam int SCREEN_W = 640;
   localparam int SCREEN_H = 480;
   localparam int COORD_W  = 10;

   typedef logic [COORD_W-1:0] coord_t;

   localparam int CURSOR_SIZE   = 8;     // side of the square
   localparam int CURSOR_HOME_X = 320;
   localparam int CURSOR_HOME_Y = 240;

   // noise bar rows, bar spans the full width
   localparam int NOISE_Y0 = 400;
   localparam int NOISE_H  = 16;

   ////////////////////////////////////////
   // colours
   ////////////////////////////////////////
   typedef struct packed {
      logic [7:0] r;
      logic [7:0] g;
      logic [7:0] b;
   } rgb24_t;

   typedef struct packed {
      logic [3:0] r;
      logic [3:0] g;
      logic [3:0] b;
   } rgb12_t;

   typedef logic [1:0] palette_idx_t;

   localparam rgb12_t CURSOR_PALETTE [4] = '{
      '{r: 4'hf, g: 4'hf, b: 4'hf},   // white
      '{r: 4'hf, g: 4'h0, b: 4'h0},   // red
      '{r: 4'h0, g: 4'hf, b: 4'h0},   // green
      '{r: 4'h0, g: 4'h0, b: 4'hf}    // blue
   };

   ////////////////////////////////////////
   // shared bundles
   ////////////////////////////////////////
   typedef struct packed {
      logic digit_1;
      logic digit_2;
      logic digit_3;
      logic digit_4;
      logic digit_5;
      logic digit_6;
      logic digit_7;
      logic digit_8;
      logic m;
      logic space;
      logic left;
      logic right;
      logic up;
      logic down;
      logic spare;   // never set
   } held_keys_t;

   typedef struct packed {
      coord_t       x;
      coord_t       y;
      palette_idx_t palette_idx;
   } cursor_state_t;

   typedef struct packed {
      coord_t x;
      coord_t y;
      rgb24_t bg;
   } pixel_req_t;

   // hit flags and sampled sources between the two stages
   typedef struct packed {
      rgb24_t     bg;
      logic       cursor_hit;
      logic       bar_hit;
      rgb12_t     cursor_rgb;
      logic [4:0] noise;
   } pixel_mid_t;

endpackage

/* src/scan_codes.svh */
`ifndef SCAN_CODES_SVH
`define SCAN_CODES_SVH

// decoded key events, break = make with bit 7 set

// digits 1 to 8
`define SC_MAKE_1          8'h16
`define SC_BREAK_1         8'h96
`define SC_MAKE_2          8'h1e
`define SC_BREAK_2         8'h9e
`define SC_MAKE_3          8'h26
`define SC_BREAK_3         8'ha6
`define SC_MAKE_4          8'h25
`define SC_BREAK_4         8'ha5
`define SC_MAKE_5          8'h2e
`define SC_BREAK_5         8'hae
`define SC_MAKE_6          8'h36
`define SC_BREAK_6         8'hb6
`define SC_MAKE_7          8'h3d
`define SC_BREAK_7         8'hbd
`define SC_MAKE_8          8'h3e
`define SC_BREAK_8         8'hbe

`define SC_MAKE_M          8'h3a   // slow motion
`define SC_BREAK_M         8'hba
`define SC_MAKE_SPACE      8'h29   // colour change
`define SC_BREAK_SPACE     8'ha9

// arrows, extended prefix already stripped
`define SC_MAKE_LEFT       8'h6b
`define SC_BREAK_LEFT      8'heb
`define SC_MAKE_RIGHT      8'h74
`define SC_BREAK_RIGHT     8'hf4
`define SC_MAKE_UP         8'h75
`define SC_BREAK_UP        8'hf5
`define SC_MAKE_DOWN       8'h72
`define SC_BREAK_DOWN      8'hf2

`endif
